//--- verilog/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_e;

    // where decode takes each source operand from
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_ex,
        fwd_rs
    } fwd_sel_e;

    typedef struct packed {
        logic [31:0] pc;
    } fetch_to_decode_t;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] opa;
        logic [31:0] opb;
        logic [31:0] store_data;
        logic [4:0]  dest;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } decode_to_execute_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        reg_write;
        logic        mem_read;
    } execute_to_result_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;
    } writeback_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } branch_t;

    // what the hazard unit sees of a later stage
    typedef struct packed {
        logic       valid;
        logic [4:0] dest;
        logic       reg_write;
        logic       mem_read;
    } stage_info_t;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_slt     = 6'h2a;

endpackage

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             decode_allowin,
    input  branch_t          br,
    output logic             fd_valid,
    output fetch_to_decode_t fd_bus,
    output logic             inst_sram_en,
    output logic [31:0]      inst_sram_addr
);

    logic        running;
    logic [31:0] pc;
    logic        br_pending;
    logic [31:0] br_target_q;
    logic [31:0] next_pc;

    // pc is the address of the word now in decode.
    // a taken branch redirects the fetch after its delay slot
    assign next_pc        = br_pending ? br_target_q : pc + 32'd4;
    assign inst_sram_en   = running && decode_allowin;
    assign inst_sram_addr = next_pc;
    assign fd_bus.pc      = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running    <= 1'b0;
            pc         <= reset_pc - 32'd4;
            fd_valid   <= 1'b0;
            br_pending <= 1'b0;
        end else begin
            running <= 1'b1;
            if (decode_allowin) begin
                fd_valid <= running;
                if (running) begin
                    pc         <= next_pc;
                    br_pending <= br.taken;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_sram_en) begin
            br_target_q <= br.target;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        inst_sram_en |-> inst_sram_addr[1:0] == 2'b00);

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fd_valid,
    input  fetch_to_decode_t   fd_bus,
    input  logic [31:0]        inst_rdata,
    input  logic               execute_allowin,
    input  writeback_t         wb,
    input  logic [31:0]        ex_result,
    input  logic [31:0]        rs_data,
    input  fwd_sel_e           fwd_a,
    input  fwd_sel_e           fwd_b,
    input  logic               decode_stall,
    output logic               decode_allowin,
    output logic               de_valid,
    output decode_to_execute_t de_bus,
    output branch_t            br,
    output logic [4:0]         rs_num,
    output logic [4:0]         rt_num,
    output logic               uses_rs,
    output logic               uses_rt,
    output logic               is_branch
);

    logic [31:0] rf [32];
    logic        use_held;
    logic [31:0] held_inst;
    logic [31:0] inst;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic [31:0] imm_ext;
    logic [31:0] rf_a;
    logic [31:0] rf_b;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] pc_plus4;
    logic        decode_fire;
    alu_op_e     alu_op;
    logic        r_known;
    logic        use_imm;
    logic        imm_zext;
    logic        writes;
    logic        dest_rd;
    logic        mem_read;
    logic        mem_write;
    logic        need_rs;
    logic        need_rt;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    logic [4:0]  dest;

    // keep the word while stalled since the sram output may move on
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            use_held <= 1'b0;
        end else begin
            use_held <= !decode_allowin;
        end
    end

    always_ff @(posedge clk) begin
        if (!decode_allowin && !use_held) begin
            held_inst <= inst_rdata;
        end
    end

    assign inst   = use_held ? held_inst : inst_rdata;
    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];
    assign rs_num = inst[25:21];
    assign rt_num = inst[20:16];

    always_comb begin
        alu_op    = alu_add;
        r_known   = 1'b0;
        use_imm   = 1'b0;
        imm_zext  = 1'b0;
        writes    = 1'b0;
        dest_rd   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        need_rs   = 1'b0;
        need_rt   = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode)
            op_special: begin
                r_known = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    default: r_known = 1'b0;
                endcase
                writes  = r_known;
                dest_rd = 1'b1;
                need_rs = r_known;
                need_rt = r_known;
            end
            op_addiu: begin
                use_imm = 1'b1;
                writes  = 1'b1;
                need_rs = 1'b1;
            end
            op_ori: begin
                alu_op   = alu_or;
                use_imm  = 1'b1;
                imm_zext = 1'b1;
                writes   = 1'b1;
                need_rs  = 1'b1;
            end
            op_lui: begin
                alu_op   = alu_lui;
                use_imm  = 1'b1;
                imm_zext = 1'b1;
                writes   = 1'b1;
            end
            op_lw: begin
                use_imm  = 1'b1;
                writes   = 1'b1;
                mem_read = 1'b1;
                need_rs  = 1'b1;
            end
            op_sw: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
                need_rs   = 1'b1;
                need_rt   = 1'b1;
            end
            op_beq: begin
                is_beq  = 1'b1;
                need_rs = 1'b1;
                need_rt = 1'b1;
            end
            op_bne: begin
                is_bne  = 1'b1;
                need_rs = 1'b1;
                need_rt = 1'b1;
            end
            op_j:    is_j = 1'b1;
            default: ;
        endcase
    end

    assign dest      = dest_rd ? inst[15:11] : rt_num;
    assign imm_ext   = imm_zext ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign uses_rs   = fd_valid && need_rs;
    assign uses_rt   = fd_valid && need_rt;
    assign is_branch = fd_valid && (is_beq || is_bne);

    // register file written by the result stage at the clock edge
    always_ff @(posedge clk) begin
        if (wb.we && wb.dest != 5'd0) begin
            rf[wb.dest] <= wb.data;
        end
    end

    // r0 reads as zero; same-cycle writeback is bypassed
    assign rf_a = (rs_num == 5'd0) ? 32'd0 :
                  (wb.we && wb.dest == rs_num) ? wb.data : rf[rs_num];
    assign rf_b = (rt_num == 5'd0) ? 32'd0 :
                  (wb.we && wb.dest == rt_num) ? wb.data : rf[rt_num];

    assign src_a = (fwd_a == fwd_ex) ? ex_result : (fwd_a == fwd_rs) ? rs_data : rf_a;
    assign src_b = (fwd_b == fwd_ex) ? ex_result : (fwd_b == fwd_rs) ? rs_data : rf_b;

    assign decode_fire    = fd_valid && !decode_stall && execute_allowin;
    assign decode_allowin = !fd_valid || (!decode_stall && execute_allowin);
    assign de_valid       = fd_valid && !decode_stall;

    // resolved here and applied by fetch after the delay slot
    assign pc_plus4  = fd_bus.pc + 32'd4;
    assign br.taken  = decode_fire &&
                       (is_j || (is_beq && src_a == src_b) || (is_bne && src_a != src_b));
    assign br.target = is_j ? {pc_plus4[31:28], inst[25:0], 2'b00}
                            : pc_plus4 + {imm_ext[29:0], 2'b00};

    always_comb begin
        de_bus.pc         = fd_bus.pc;
        de_bus.alu_op     = alu_op;
        de_bus.opa        = src_a;
        de_bus.opb        = use_imm ? imm_ext : src_b;
        de_bus.store_data = src_b;
        de_bus.dest       = dest;
        de_bus.reg_write  = writes && dest != 5'd0;
        de_bus.mem_read   = mem_read;
        de_bus.mem_write  = mem_write;
    end

    // fetch must hold the stalled instruction in place
    stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
        fd_valid && !decode_allowin |=> fd_valid && $stable(fd_bus.pc));

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               de_valid,
    input  decode_to_execute_t de_bus,
    input  logic               result_allowin,
    output logic               execute_allowin,
    output logic               er_valid,
    output execute_to_result_t er_bus,
    output stage_info_t        ex_info,
    output logic [31:0]        ex_result,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_wen,
    output logic [31:0]        data_sram_addr,
    output logic [31:0]        data_sram_wdata
);

    logic               ex_valid;
    decode_to_execute_t ex_q;
    logic [31:0]        alu_out;

    // single cycle so the stage is always ready to go
    assign execute_allowin = !ex_valid || result_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (execute_allowin) begin
            ex_valid <= de_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (de_valid && execute_allowin) begin
            ex_q <= de_bus;
        end
    end

    always_comb begin
        case (ex_q.alu_op)
            alu_sub: alu_out = ex_q.opa - ex_q.opb;
            alu_and: alu_out = ex_q.opa & ex_q.opb;
            alu_or:  alu_out = ex_q.opa | ex_q.opb;
            alu_xor: alu_out = ex_q.opa ^ ex_q.opb;
            alu_slt: alu_out = {31'b0, $signed(ex_q.opa) < $signed(ex_q.opb)};
            alu_lui: alu_out = {ex_q.opb[15:0], 16'b0};
            default: alu_out = ex_q.opa + ex_q.opb;
        endcase
    end

    assign ex_result = alu_out;
    assign er_valid  = ex_valid;

    always_comb begin
        er_bus.pc        = ex_q.pc;
        er_bus.result    = alu_out;
        er_bus.dest      = ex_q.dest;
        er_bus.reg_write = ex_q.reg_write;
        er_bus.mem_read  = ex_q.mem_read;
    end

    always_comb begin
        ex_info.valid     = ex_valid;
        ex_info.dest      = ex_q.dest;
        ex_info.reg_write = ex_q.reg_write;
        ex_info.mem_read  = ex_q.mem_read;
    end

    // request goes out now and the read data comes back in result
    assign data_sram_en    = ex_valid && (ex_q.mem_read || ex_q.mem_write);
    assign data_sram_wen   = (ex_valid && ex_q.mem_write) ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_out;
    assign data_sram_wdata = ex_q.store_data;

endmodule

//--- verilog/result_stage.sv
`timescale 1ns/1ps

module result_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               er_valid,
    input  execute_to_result_t er_bus,
    input  logic [31:0]        data_rdata,
    output logic               result_allowin,
    output writeback_t         wb,
    output stage_info_t        rs_info,
    output logic [31:0]        rs_data,
    output logic               debug_wb_valid,
    output logic [31:0]        debug_wb_pc,
    output logic               debug_wb_rf_we,
    output logic [4:0]         debug_wb_rf_wnum,
    output logic [31:0]        debug_wb_rf_wdata
);

    logic               rs_valid;
    execute_to_result_t rs_q;

    // last stage, never holds anything back
    assign result_allowin = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rs_valid <= 1'b0;
        end else if (result_allowin) begin
            rs_valid <= er_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (er_valid && result_allowin) begin
            rs_q <= er_bus;
        end
    end

    // sram read data lands this cycle
    assign rs_data = rs_q.mem_read ? data_rdata : rs_q.result;

    assign wb.we   = rs_valid && rs_q.reg_write;
    assign wb.dest = rs_q.dest;
    assign wb.data = rs_data;

    always_comb begin
        rs_info.valid     = rs_valid;
        rs_info.dest      = rs_q.dest;
        rs_info.reg_write = rs_q.reg_write;
        rs_info.mem_read  = rs_q.mem_read;
    end

    // one record per retired instruction
    assign debug_wb_valid    = rs_valid;
    assign debug_wb_pc       = rs_q.pc;
    assign debug_wb_rf_we    = wb.we;
    assign debug_wb_rf_wnum  = wb.dest;
    assign debug_wb_rf_wdata = wb.data;

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_num,
    input  logic [4:0]  rt_num,
    input  logic        uses_rs,
    input  logic        uses_rt,
    input  logic        is_branch,
    input  stage_info_t ex_info,
    input  stage_info_t rs_info,
    output fwd_sel_e    fwd_a,
    output fwd_sel_e    fwd_b,
    output logic        decode_stall
);

    logic ex_hit_a;
    logic ex_hit_b;
    logic rs_hit_a;
    logic rs_hit_b;
    logic ex_needed;
    logic stall_load;
    logic stall_branch;

    // r0 never matches a producer
    assign ex_hit_a = ex_info.valid && ex_info.reg_write && rs_num != 5'd0 && ex_info.dest == rs_num;
    assign ex_hit_b = ex_info.valid && ex_info.reg_write && rt_num != 5'd0 && ex_info.dest == rt_num;
    assign rs_hit_a = rs_info.valid && rs_info.reg_write && rs_num != 5'd0 && rs_info.dest == rs_num;
    assign rs_hit_b = rs_info.valid && rs_info.reg_write && rt_num != 5'd0 && rs_info.dest == rt_num;

    // youngest producer wins
    assign fwd_a = ex_hit_a ? fwd_ex : (rs_hit_a ? fwd_rs : fwd_rf);
    assign fwd_b = ex_hit_b ? fwd_ex : (rs_hit_b ? fwd_rs : fwd_rf);

    assign ex_needed    = (uses_rs && ex_hit_a) || (uses_rt && ex_hit_b);
    assign stall_load   = ex_needed && ex_info.mem_read;
    // compare in decode is too late for an alu result from execute
    assign stall_branch = ex_needed && is_branch;
    assign decode_stall = stall_load || stall_branch;

    stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        not (decode_stall [*3]));

endmodule

//--- verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_rdata,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_rdata,
    output logic        debug_wb_valid,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic               decode_allowin;
    logic               execute_allowin;
    logic               result_allowin;
    logic               fd_valid;
    logic               de_valid;
    logic               er_valid;
    fetch_to_decode_t   fd_bus;
    decode_to_execute_t de_bus;
    execute_to_result_t er_bus;
    branch_t            br;
    writeback_t         wb;
    stage_info_t        ex_info;
    stage_info_t        rs_info;
    logic [31:0]        ex_result;
    logic [31:0]        rs_data;
    logic [4:0]         rs_num;
    logic [4:0]         rt_num;
    logic               uses_rs;
    logic               uses_rt;
    logic               is_branch;
    fwd_sel_e           fwd_a;
    fwd_sel_e           fwd_b;
    logic               decode_stall;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .decode_allowin (decode_allowin),
        .br             (br),
        .fd_valid       (fd_valid),
        .fd_bus         (fd_bus),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_sram_addr)
    );

    decode_stage u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .fd_valid        (fd_valid),
        .fd_bus          (fd_bus),
        .inst_rdata      (inst_rdata),
        .execute_allowin (execute_allowin),
        .wb              (wb),
        .ex_result       (ex_result),
        .rs_data         (rs_data),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .decode_stall    (decode_stall),
        .decode_allowin  (decode_allowin),
        .de_valid        (de_valid),
        .de_bus          (de_bus),
        .br              (br),
        .rs_num          (rs_num),
        .rt_num          (rt_num),
        .uses_rs         (uses_rs),
        .uses_rt         (uses_rt),
        .is_branch       (is_branch)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .de_valid        (de_valid),
        .de_bus          (de_bus),
        .result_allowin  (result_allowin),
        .execute_allowin (execute_allowin),
        .er_valid        (er_valid),
        .er_bus          (er_bus),
        .ex_info         (ex_info),
        .ex_result       (ex_result),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    result_stage u_result (
        .clk               (clk),
        .rst_n             (rst_n),
        .er_valid          (er_valid),
        .er_bus            (er_bus),
        .data_rdata        (data_rdata),
        .result_allowin    (result_allowin),
        .wb                (wb),
        .rs_info           (rs_info),
        .rs_data           (rs_data),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    hazard_unit u_hazard (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs_num       (rs_num),
        .rt_num       (rt_num),
        .uses_rs      (uses_rs),
        .uses_rt      (uses_rt),
        .is_branch    (is_branch),
        .ex_info      (ex_info),
        .rs_info      (rs_info),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .decode_stall (decode_stall)
    );

endmodule

//--- tb/isa_model.svh
// expected trace record of one retired instruction
typedef struct packed {
    logic [31:0] pc;
    logic        we;
    logic [4:0]  wnum;
    logic [31:0] wdata;
} trace_t;

// architectural state, stepped one instruction at a time
logic [31:0] m_rf  [32];
logic [31:0] m_mem [1024];
logic [31:0] m_pc;
logic [31:0] m_npc;

// initial data memory contents, per word index
function automatic logic [31:0] fill_word(int i);
    return (i * 32'h9e37_79b9) ^ {i[15:0], i[31:16]} ^ 32'h5a5a_a5a5;
endfunction

function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        m_rf[i] = 32'd0;
    end
    for (int i = 0; i < 1024; i++) begin
        m_mem[i] = fill_word(i);
    end
    m_pc  = reset_pc;
    m_npc = reset_pc + 32'd4;
endfunction

function automatic trace_t isa_step();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] addr;
    logic [31:0] next;
    trace_t      t;
    inst    = imem[m_pc[11:2]];
    a       = m_rf[inst[25:21]];
    b       = m_rf[inst[20:16]];
    sext    = {{16{inst[15]}}, inst[15:0]};
    addr    = a + sext;
    next    = m_npc + 32'd4;
    t.pc    = m_pc;
    t.we    = 1'b0;
    t.wnum  = inst[20:16];
    t.wdata = 32'd0;
    case (inst[31:26])
        op_special: begin
            t.we   = 1'b1;
            t.wnum = inst[15:11];
            case (inst[5:0])
                fn_addu: t.wdata = a + b;
                fn_subu: t.wdata = a - b;
                fn_and:  t.wdata = a & b;
                fn_or:   t.wdata = a | b;
                fn_xor:  t.wdata = a ^ b;
                fn_slt:  t.wdata = {31'd0, $signed(a) < $signed(b)};
                default: t.we = 1'b0;
            endcase
        end
        op_addiu: {t.we, t.wdata} = {1'b1, addr};
        op_ori:   {t.we, t.wdata} = {1'b1, a | {16'd0, inst[15:0]}};
        op_lui:   {t.we, t.wdata} = {1'b1, inst[15:0], 16'd0};
        op_lw:    {t.we, t.wdata} = {1'b1, m_mem[addr[11:2]]};
        op_sw:    m_mem[addr[11:2]] = b;
        // delay slot already sits in m_npc
        op_beq:   if (a == b) next = m_npc + {sext[29:0], 2'b00};
        op_bne:   if (a != b) next = m_npc + {sext[29:0], 2'b00};
        op_j:     next = {m_npc[31:28], inst[25:0], 2'b00};
        default:  ;
    endcase
    // r0 is never written
    if (t.wnum == 5'd0) t.we = 1'b0;
    if (t.we) m_rf[t.wnum] = t.wdata;
    m_pc  = m_npc;
    m_npc = next;
    return t;
endfunction

//--- tb/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top import cpu_pkg::*; ();

    localparam logic [31:0] reset_pc    = 32'h0000_0100;
    localparam int          base        = 64;
    localparam int          pro_len     = 5;
    localparam int          body_len    = 160;
    localparam int          end_idx     = pro_len + body_len;
    localparam int          prog_len    = end_idx + 2;
    localparam int          cycle_limit = 8 * prog_len + 200;
    localparam logic [31:0] end_pc      = reset_pc + 32'(4 * end_idx);

    logic        clk;
    logic        rst_n;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_rdata;
    logic        debug_wb_valid;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    integer      seed;
    int          trace_errors = 0;
    int          reset_errors = 0;
    int          count_errors = 0;
    int          retired      = 0;
    int          model_count  = 0;
    int          cycles       = 0;
    int          quiet_cycles = 0;
    logic        trace_done   = 1'b0;

    `include "isa_model.svh"

    trace_t exp_rec;
    trace_t pre_rec;

    cpu_top #(
        .reset_pc (reset_pc)
    ) dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_rdata        (inst_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_rdata        (data_rdata),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    function automatic logic [31:0] rtype_word(logic [5:0] fn, logic [4:0] rs,
                                               logic [4:0] rt, logic [4:0] rd);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rs,
                                               logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // sources r0..r5, r1 being the data base
    function automatic logic [4:0] src_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[2:0] > 3'd5) ? 5'd2 : {2'b0, r[2:0]};
    endfunction

    // r2..r5, now and then r0
    function automatic logic [4:0] dest_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[2:0] == 3'd7) ? 5'd0 : 5'd2 + {3'b0, r[1:0]};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] w;
        logic [31:0] jt;
        logic [15:0] off;
        logic [15:0] last_off;
        logic [15:0] br_off;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic        after_sw;
        logic        in_slot;
        logic        branch_ok;
        for (int i = 0; i < 1024; i++) begin
            // unknown opcode, runs as a no-op
            imem[i] = {6'h3f, i[25:0]};
            dmem[i] = fill_word(i);
        end
        // base register and a dependent chain to seed r2..r5
        imem[base]     = itype_word(op_ori, 5'd0, 5'd1, 16'h0400);
        imem[base + 1] = itype_word(op_addiu, 5'd0, 5'd2, 16'h8123);
        imem[base + 2] = rtype_word(fn_addu, 5'd2, 5'd2, 5'd3);
        imem[base + 3] = rtype_word(fn_subu, 5'd3, 5'd1, 5'd4);
        imem[base + 4] = rtype_word(fn_xor, 5'd4, 5'd2, 5'd5);
        after_sw = 1'b0;
        in_slot  = 1'b0;
        last_off = 16'd0;
        for (int i = pro_len; i < end_idx; i++) begin
            r         = $random(seed);
            rs        = src_reg();
            rt        = src_reg();
            rd        = dest_reg();
            off       = {10'd0, r[7:4], 2'b00};
            br_off    = {14'd0, r[21:20]} + 16'd1;
            jt        = reset_pc + 32'(4 * (i + 2 + int'(r[21:20])));
            branch_ok = !in_slot && (i + 5 <= end_idx);
            if (after_sw && r[8]) begin
                w = itype_word(op_lw, 5'd1, rd, last_off);
            end else begin
                case (r[3:0])
                    4'd0:        w = rtype_word(fn_addu, rs, rt, rd);
                    4'd1:        w = rtype_word(fn_subu, rs, rt, rd);
                    4'd2:        w = rtype_word(fn_and, rs, rt, rd);
                    4'd3:        w = rtype_word(fn_or, rs, rt, rd);
                    4'd4:        w = rtype_word(fn_xor, rs, rt, rd);
                    4'd5:        w = rtype_word(fn_slt, rs, rt, rd);
                    4'd6, 4'd7:  w = itype_word(op_addiu, rs, rd, r[31:16]);
                    4'd8:        w = itype_word(op_ori, rs, rd, r[31:16]);
                    4'd9:        w = itype_word(op_lui, 5'd0, rd, r[31:16]);
                    4'd10, 4'd11: w = itype_word(op_lw, 5'd1, rd, off);
                    4'd12:       w = itype_word(op_sw, 5'd1, rt, off);
                    4'd13:       w = branch_ok ? itype_word(op_beq, rs, rt, br_off) : 32'd0;
                    4'd14:       w = branch_ok ? itype_word(op_bne, rs, rt, br_off) : 32'd0;
                    default:     w = branch_ok ? {op_j, jt[27:2]} : 32'd0;
                endcase
            end
            in_slot  = (w[31:26] == op_beq) || (w[31:26] == op_bne) || (w[31:26] == op_j);
            after_sw = (w[31:26] == op_sw);
            if (after_sw) last_off = off;
            imem[base + i] = w;
        end
        // end loop: branch to itself, nop in the delay slot
        imem[base + end_idx]     = itype_word(op_beq, 5'd0, 5'd0, 16'hffff);
        imem[base + end_idx + 1] = 32'd0;
    endtask

    task automatic report_counts();
        $display("errors: trace %0d, reset %0d, retire count %0d",
                 trace_errors, reset_errors, count_errors);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction and data sram, one cycle read
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_rdata <= imem[inst_sram_addr[11:2]];
        end
        if (data_sram_en) begin
            for (int k = 0; k < 4; k++) begin
                if (data_sram_wen[k]) begin
                    dmem[data_sram_addr[11:2]][8*k +: 8] <= data_sram_wdata[8*k +: 8];
                end
            end
            if (data_sram_wen == 4'h0) begin
                data_rdata <= dmem[data_sram_addr[11:2]];
            end
        end
    end

    // quiet outputs during reset and one cycle after
    always @(negedge clk) begin
        if (!rst_n || quiet_cycles == 0) begin
            assert (!inst_sram_en && !data_sram_en && !debug_wb_valid) else begin
                $display("CHECK FAILED at %0t: sram enable or trace valid high around reset",
                         $time);
                reset_errors++;
            end
        end
        if (rst_n) quiet_cycles++;
    end

    // compare each retired instruction with the model
    always @(negedge clk) begin
        if (rst_n && debug_wb_valid && !trace_done) begin
            exp_rec = isa_step();
            retired++;
            assert (debug_wb_pc == exp_rec.pc && debug_wb_rf_we == exp_rec.we &&
                    (!exp_rec.we || (debug_wb_rf_wnum == exp_rec.wnum &&
                                     debug_wb_rf_wdata == exp_rec.wdata))) else begin
                $display("CHECK FAILED at %0t: pc %h we %b r%0d=%h, model %h %b r%0d=%h",
                         $time, debug_wb_pc, debug_wb_rf_we, debug_wb_rf_wnum,
                         debug_wb_rf_wdata, exp_rec.pc, exp_rec.we, exp_rec.wnum,
                         exp_rec.wdata);
                trace_errors++;
            end
            if (debug_wb_pc == end_pc) trace_done = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit && !trace_done) begin
            $display("timeout: end loop not reached within %0d cycles, the core hangs",
                     cycle_limit);
            report_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        inst_rdata = 32'd0;
        data_rdata = 32'd0;
        seed       = 32'h176b;
        build_program();
        // retirements up to and including the end loop branch
        model_reset();
        do begin
            pre_rec = isa_step();
            model_count++;
        end while (pre_rec.pc != end_pc && model_count < cycle_limit);
        model_reset();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait (trace_done);
        assert (retired == model_count) else begin
            $display("CHECK FAILED at %0t: %0d instructions retired, model retires %0d",
                     $time, retired, model_count);
            count_errors++;
        end
        report_counts();
        if (trace_errors + reset_errors + count_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tb
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/hazard_unit.sv
verilog/cpu_top.sv
tb/tb_cpu_top.sv

//--- Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "Result: PASSED" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
